// File: dly_config.svh
/*
 * Build-time sizing for the delay bank.
 * Included by the channel package and by every module that sizes ports or
 * holds the default tap.
 */

`ifndef DLY_CONFIG_SVH
`define DLY_CONFIG_SVH

// ********************
// bank geometry
// ********************

`define DLY_NUM_CHAN    4   // delay channels in the bank
`define DLY_TAP_WIDTH   6   // tap range 0..63, line depth follows

// tap value after reset and after a load command
`define DLY_DEFAULT_TAP 5

`endif

// File: dly_cmd_pkg.sv
/*
 * Control types for the delay bank.
 * Holds the user strobe bundle and the single-cycle command that the
 * decode stage sends to one channel.
 */

package dly_cmd_pkg;

    // ********************
    // user side levels
    // ********************
    typedef struct packed {
        logic ld;       // load default tap, acts on rising edge
        logic adj;      // move tap one step, acts on rising edge
        logic incdec;   // step direction, 1 counts up
    } dly_ctrl_t;

    // ********************
    // per channel pulse
    // ********************
    typedef struct packed {
        logic load;     // set tap to default
        logic step;     // move tap by one
        logic up;       // direction of the step
    } chan_cmd_t;

endpackage

// File: dly_chan_pkg.sv
/*
 * Channel side types of the delay bank.
 * Tap value and channel index widths follow the config macros, so any
 * module using these types stays in step with the bank size.
 */

`include "dly_config.svh"

package dly_chan_pkg;

    // one channel's delay setting, delay is tap+1 cycles
    typedef logic [`DLY_TAP_WIDTH-1:0] tap_t;

    // index of the channel a strobe or readback refers to
    typedef logic [$clog2(`DLY_NUM_CHAN)-1:0] chan_sel_t;

    // ********************
    // notes
    // ********************
    // taps saturate at both ends, there is no wrap
    // channel 0 maps to data bit 0 on both sides of the bank
    // the select is shared by the command path and the readback

endpackage

// File: dly_cmd_decode.sv
/*
 * Decode stage. Finds rising edges on the load and adjust strobes and
 * sends a one-cycle command to the channel picked by the select input.
 * All other channel slots stay idle, so at most one command is live.
 */

`timescale 1ns/1ns

`include "dly_config.svh"

module dly_cmd_decode (
    input  logic                                        clk,
    input  logic                                        reset,
    input  dly_chan_pkg::chan_sel_t                     sel_i,
    input  dly_cmd_pkg::dly_ctrl_t                      ctrl_i,
    output dly_cmd_pkg::chan_cmd_t [`DLY_NUM_CHAN-1:0]  cmd_o
);

    logic                   ld_prev;    // strobe levels from the last edge
    logic                   adj_prev;
    logic                   ld_rise;
    logic                   adj_rise;
    dly_cmd_pkg::chan_cmd_t cmd_next;   // command for the selected slot

    assign ld_rise  = ctrl_i.ld & ~ld_prev;
    assign adj_rise = ctrl_i.adj & ~adj_prev;

    // load has priority when both strobes rise together
    always_comb begin
        cmd_next.load = ld_rise;
        cmd_next.step = adj_rise & ~ld_rise;
        cmd_next.up   = ctrl_i.incdec & cmd_next.step;
    end

    // ********************
    // edge history and one-hot steering
    // ********************
    always_ff @(posedge clk) begin
        if (reset) begin
            ld_prev  <= 1'b0;   // a strobe high at release counts as an edge
            adj_prev <= 1'b0;
            cmd_o    <= '0;
        end else begin
            ld_prev  <= ctrl_i.ld;
            adj_prev <= ctrl_i.adj;
            for (int k = 0; k < `DLY_NUM_CHAN; k++) begin
                if (sel_i == k) begin
                    cmd_o[k] <= cmd_next;
                end else begin
                    cmd_o[k] <= '0;
                end
            end
        end
    end

endmodule

// File: dly_channel.sv
/*
 * Execute stage for one delay channel. A saturating tap counter follows
 * the load and step commands, and a shift register delays the data bit
 * by tap+1 clocks. Stands in for the vendor delay primitive.
 */

`timescale 1ns/1ns

`include "dly_config.svh"

module dly_channel (
    input  logic                   clk,
    input  logic                   reset,
    input  dly_cmd_pkg::chan_cmd_t cmd_i,
    input  logic                   data_i,
    output dly_chan_pkg::tap_t     tap_o,
    output logic                   data_o
);

    // one stage per possible tap value
    localparam int unsigned LINE_DEPTH = 1 << `DLY_TAP_WIDTH;

    localparam dly_chan_pkg::tap_t DEFAULT_TAP = `DLY_DEFAULT_TAP;
    localparam dly_chan_pkg::tap_t TAP_MAX     = {`DLY_TAP_WIDTH{1'b1}};

    dly_chan_pkg::tap_t    tap_q;
    logic                  tap_at_max;
    logic                  tap_at_min;
    logic [LINE_DEPTH-1:0] line_q;      // bit 0 is the newest sample

    assign tap_at_max = (tap_q == TAP_MAX);
    assign tap_at_min = (tap_q == '0);

    // ********************
    // tap counter
    // ********************
    always_ff @(posedge clk) begin
        if (reset) begin
            tap_q <= DEFAULT_TAP;
        end else if (cmd_i.load) begin
            tap_q <= DEFAULT_TAP;
        end else if (cmd_i.step) begin
            if (cmd_i.up) begin
                if (!tap_at_max) begin
                    tap_q <= tap_q + 1'b1;
                end
            end else begin
                if (!tap_at_min) begin
                    tap_q <= tap_q - 1'b1;
                end
            end
        end
    end

    // ********************
    // delay line
    // ********************
    // the line is cleared so the output starts at 0 after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            line_q <= '0;
        end else begin
            line_q <= {line_q[LINE_DEPTH-2:0], data_i};
        end
    end

    // stage tap holds the input from tap+1 edges back
    assign data_o = line_q[tap_q];
    assign tap_o  = tap_q;

endmodule

// File: dly_tap_readback.sv
/*
 * Result stage. Picks the tap of the selected channel and registers it
 * for the readback port, one clock after select and taps are sampled.
 */

`timescale 1ns/1ns

`include "dly_config.svh"

module dly_tap_readback (
    input  logic                                    clk,
    input  logic                                    reset,
    input  dly_chan_pkg::chan_sel_t                 sel_i,
    input  dly_chan_pkg::tap_t [`DLY_NUM_CHAN-1:0]  taps_i,
    output dly_chan_pkg::tap_t                      tap_val_o
);

    // single indexed mux feeding the output register
    always_ff @(posedge clk) begin
        if (reset) begin
            tap_val_o <= '0;
        end else begin
            tap_val_o <= taps_i[sel_i];
        end
    end

endmodule

// File: dly_bank_top.sv
/*
 * Top level of the four channel delay bank. Strobes are decoded into
 * per channel commands, each channel delays its own data bit, and the
 * selected channel's tap is read back on tap_val_o.
 */

`timescale 1ns/1ns

`include "dly_config.svh"

module dly_bank_top (
    input  logic                        clk,
    input  logic                        reset,
    input  dly_chan_pkg::chan_sel_t     sel_i,
    input  dly_cmd_pkg::dly_ctrl_t      ctrl_i,
    input  logic [`DLY_NUM_CHAN-1:0]    data_i,
    output logic [`DLY_NUM_CHAN-1:0]    data_o,
    output dly_chan_pkg::tap_t          tap_val_o
);

    dly_cmd_pkg::chan_cmd_t [`DLY_NUM_CHAN-1:0] chan_cmd;   // one-hot command slots
    dly_chan_pkg::tap_t     [`DLY_NUM_CHAN-1:0] chan_tap;   // live tap per channel

    // ********************
    // decode
    // ********************
    dly_cmd_decode u_decode (
        .clk    (clk),
        .reset  (reset),
        .sel_i  (sel_i),
        .ctrl_i (ctrl_i),
        .cmd_o  (chan_cmd)
    );

    // ********************
    // execute
    // ********************
    for (genvar k = 0; k < `DLY_NUM_CHAN; k++) begin : g_chan
        dly_channel u_channel (
            .clk    (clk),
            .reset  (reset),
            .cmd_i  (chan_cmd[k]),
            .data_i (data_i[k]),
            .tap_o  (chan_tap[k]),
            .data_o (data_o[k])
        );
    end

    // ********************
    // result
    // ********************
    dly_tap_readback u_readback (
        .clk       (clk),
        .reset     (reset),
        .sel_i     (sel_i),
        .taps_i    (chan_tap),
        .tap_val_o (tap_val_o)
    );

endmodule

// File: tb_dly_bank.sv
/*
 * Directed testbench for the delay bank. Test tasks drive select, strobes
 * and data on the falling edge. Taps and delayed data are checked against
 * a small model of the bank's rules.
 */

`timescale 1ns/1ns

`include "dly_config.svh"

module tb_dly_bank;

    localparam int RUN_LIMIT  = 5000;                   // watchdog in clock cycles
    localparam int LINE_DEPTH = 1 << `DLY_TAP_WIDTH;
    localparam int MAX_TAP    = LINE_DEPTH - 1;

    logic                       clk;
    logic                       reset;
    dly_chan_pkg::chan_sel_t    sel_i;
    dly_cmd_pkg::dly_ctrl_t     ctrl_i;
    logic [`DLY_NUM_CHAN-1:0]   data_i;
    logic [`DLY_NUM_CHAN-1:0]   data_o;
    dly_chan_pkg::tap_t         tap_val_o;

    int                    errors;
    int                    checks;
    int                    model_tap [`DLY_NUM_CHAN];
    logic [LINE_DEPTH-1:0] hist [`DLY_NUM_CHAN];      // bit 0 is the newest sample
    int                    hist_cnt;                  // samples taken since reset

    dly_bank_top dly_bank_top_i (
        .clk       (clk),
        .reset     (reset),
        .sel_i     (sel_i),
        .ctrl_i    (ctrl_i),
        .data_i    (data_i),
        .data_o    (data_o),
        .tap_val_o (tap_val_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // input history as the bank sees it at each rising edge
    always @(posedge clk) begin
        if (reset) begin
            hist_cnt <= 0;
            for (int k = 0; k < `DLY_NUM_CHAN; k++) begin
                hist[k] <= '0;
            end
        end else begin
            hist_cnt <= hist_cnt + 1;
            for (int k = 0; k < `DLY_NUM_CHAN; k++) begin
                hist[k] <= {hist[k][LINE_DEPTH-2:0], data_i[k]};
            end
        end
    end

    // ********************
    // helpers
    // ********************
    task automatic tick(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    // saturating step, no wrap at either end
    function automatic int next_tap(input int tap, input logic up);
        if (up) begin
            return (tap < MAX_TAP) ? tap + 1 : tap;
        end
        return (tap > 0) ? tap - 1 : tap;
    endfunction

    // strobe high for one cycle then low for one, model follows
    task automatic pulse(input int ch, input logic ld, input logic adj, input logic up);
        @(negedge clk);
        sel_i         = ch;
        ctrl_i.ld     = ld;
        ctrl_i.adj    = adj;
        ctrl_i.incdec = up;
        @(negedge clk);
        ctrl_i.ld     = 1'b0;
        ctrl_i.adj    = 1'b0;
        if (ld) begin
            model_tap[ch] = `DLY_DEFAULT_TAP;
        end else if (adj) begin
            model_tap[ch] = next_tap(model_tap[ch], up);
        end
    endtask

    task automatic read_tap(input int ch, input int limit);
        int waited;
        @(negedge clk);
        sel_i  = ch;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (tap_val_o !== model_tap[ch] && waited < limit);
        checks++;
        if (tap_val_o !== model_tap[ch]) begin
            errors++;
            $display("Fail at %0t: channel %0d tap reads %0d, expected %0d",
                     $time, ch, tap_val_o, model_tap[ch]);
        end
    endtask

    task automatic check_data();
        for (int k = 0; k < `DLY_NUM_CHAN; k++) begin
            if (hist_cnt > model_tap[k]) begin
                checks++;
                if (data_o[k] !== hist[k][model_tap[k]]) begin
                    errors++;
                    $display("Fail at %0t: channel %0d data %b, expected %b at tap %0d",
                             $time, k, data_o[k], hist[k][model_tap[k]], model_tap[k]);
                end
            end
        end
    endtask

    // ********************
    // tests
    // ********************
    task automatic test_reset_taps();
        for (int k = 0; k < `DLY_NUM_CHAN; k++) begin
            read_tap(k, 1);
        end
    endtask

    task automatic test_select_one();
        for (int i = 0; i < 3; i++) begin
            pulse(2, 1'b0, 1'b1, 1'b1);
        end
        pulse(2, 1'b0, 1'b1, 1'b0);     // 5 + 3 - 1 gives 7
        for (int k = 0; k < `DLY_NUM_CHAN; k++) begin
            read_tap(k, 4);
        end
    endtask

    task automatic test_saturation();
        for (int i = 0; i < 70; i++) begin
            pulse(1, 1'b0, 1'b1, 1'b1);
        end
        read_tap(1, 4);
        for (int i = 0; i < 70; i++) begin
            pulse(1, 1'b0, 1'b1, 1'b0);
        end
        read_tap(1, 4);
    endtask

    task automatic test_held_strobe();
        @(negedge clk);
        sel_i         = 3;
        ctrl_i.adj    = 1'b1;
        ctrl_i.incdec = 1'b1;
        tick(10);
        ctrl_i.adj    = 1'b0;
        model_tap[3]  = next_tap(model_tap[3], 1'b1);   // one step only
        read_tap(3, 4);
        pulse(3, 1'b1, 1'b0, 1'b0);
        read_tap(3, 4);
    endtask

    task automatic test_data_delay();
        for (int i = 0; i < 5; i++) begin
            pulse(0, 1'b0, 1'b1, 1'b0);
        end
        for (int i = 0; i < 12; i++) begin
            pulse(1, 1'b0, 1'b1, 1'b1);
        end
        pulse(3, 1'b0, 1'b1, 1'b0);
        pulse(3, 1'b0, 1'b1, 1'b0);
        tick(2);                        // let the last tap change land
        for (int c = 0; c < 100; c++) begin
            @(negedge clk);
            check_data();
            data_i = $urandom;
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        void'($urandom(32'hfe3d2e0c));
        reset  = 1'b1;
        sel_i  = '0;
        ctrl_i = '0;
        data_i = '0;
        for (int k = 0; k < `DLY_NUM_CHAN; k++) begin
            model_tap[k] = `DLY_DEFAULT_TAP;
        end
        tick(5);
        reset = 1'b0;
        test_reset_taps();
        test_select_one();
        test_saturation();
        test_held_strobe();
        test_data_delay();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        for (int i = 0; i < RUN_LIMIT; i++) begin
            @(posedge clk);
        end
        $display("timeout: tests did not complete within %0d cycles", RUN_LIMIT);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
dly_cmd_pkg.sv
dly_chan_pkg.sv
dly_cmd_decode.sv
dly_channel.sv
dly_tap_readback.sv
dly_bank_top.sv
tb_dly_bank.sv

// File: Bender.yml
package:
  name: dly_bank

sources:
  - include_dirs:
      - .
    files:
      - dly_cmd_pkg.sv
      - dly_chan_pkg.sv
      - dly_cmd_decode.sv
      - dly_channel.sv
      - dly_tap_readback.sv
      - dly_bank_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dly_bank.sv
